//--- verilog/vwrite_params.svh
`ifndef VWRITE_PARAMS_SVH
`define VWRITE_PARAMS_SVH

// Buffer address and word widths
`define VW_ADDR_W 10
`define VW_DATA_W 32

// Generator counter widths
`define VW_PERIOD_W 8
`define VW_DELAY_W 4

// Databus burst length and address
`define VW_LEN_W 8
`define VW_EXT_ADDR_W 32

`endif

//--- verilog/vwrite_bus_pkg.sv
`include "vwrite_params.svh"

package vwrite_bus_pkg;

   typedef logic [`VW_ADDR_W-1:0]     addr_t;
   typedef logic [`VW_DATA_W-1:0]     word_t;
   typedef logic [`VW_LEN_W-1:0]      len_t;
   typedef logic [`VW_EXT_ADDR_W-1:0] ext_addr_t;

   // Buffer write port, driven by the store side
   typedef struct packed {
      logic  write;
      addr_t addr;
      word_t data;
   } mem_wport_t;

   // Buffer read port, data comes back one cycle later
   typedef struct packed {
      logic  read;
      addr_t addr;
   } mem_rport_t;

   // Databus write request
   typedef struct packed {
      logic      valid;
      ext_addr_t addr;
      len_t      len;
      word_t     wdata;
   } bus_req_t;

endpackage

//--- verilog/vwrite_cfg_pkg.sv
`include "vwrite_params.svh"

package vwrite_cfg_pkg;

   import vwrite_bus_pkg::*;

   typedef logic [`VW_PERIOD_W-1:0] period_t;
   typedef logic [`VW_DELAY_W-1:0]  delay_t;

   // One nesting level of the address pattern
   typedef struct packed {
      addr_t   start;
      period_t per;
      period_t duty;
      addr_t   iter;
      addr_t   incr;
      addr_t   shift;
   } gen_cfg_t;

   // Start is the base address within one half of the buffer
   typedef struct packed {
      gen_cfg_t gen;
      delay_t   delay;
   } store_cfg_t;

   // Write side has no start field, it always reads from the half base
   typedef struct packed {
      period_t   per;
      period_t   duty;
      addr_t     iter;
      addr_t     incr;
      addr_t     shift;
      len_t      len;
      ext_addr_t ext_addr;
      logic      enabled;
   } write_cfg_t;

   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN
   } gen_state_t;

endpackage

//--- verilog/addr_gen.sv
module addr_gen
   import vwrite_bus_pkg::*;
   import vwrite_cfg_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     run_i,
   input  gen_cfg_t cfg_i,
   input  delay_t   delay_i,
   input  logic     ready_i,
   output logic     valid_o,
   output addr_t    addr_o,
   output logic     done_o
);

   gen_state_t state_q;
   delay_t     dly_cnt_q;
   period_t    inner_q;
   addr_t      outer_q;

   // Latched pattern
   period_t    per_q;
   period_t    duty_q;
   addr_t      iter_q;
   addr_t      incr_q;
   addr_t      shift_q;
   addr_t      addr_q;

   logic       last_inner;
   logic       last_outer;
   logic       step;

   assign last_inner = (inner_q == per_q - period_t'(1));
   assign last_outer = (outer_q == iter_q - addr_t'(1));
   assign step       = (state_q == GEN_RUN) && ready_i;

   // Only the first duty steps of every period produce an address
   assign valid_o = (state_q == GEN_RUN) && (inner_q < duty_q);
   assign addr_o  = addr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q   <= GEN_IDLE;
         dly_cnt_q <= '0;
         inner_q   <= '0;
         outer_q   <= '0;
         done_o    <= 1'b1;
      end else if (run_i) begin
         inner_q   <= '0;
         outer_q   <= '0;
         dly_cnt_q <= delay_i;
         if (cfg_i.per == '0 || cfg_i.iter == '0) begin
            // Empty pattern, nothing to step through
            state_q <= GEN_IDLE;
            done_o  <= 1'b1;
         end else begin
            state_q <= (delay_i == '0) ? GEN_RUN : GEN_DELAY;
            done_o  <= 1'b0;
         end
      end else begin
         case (state_q)
            GEN_DELAY: begin
               dly_cnt_q <= dly_cnt_q - delay_t'(1);
               if (dly_cnt_q == delay_t'(1)) begin
                  state_q <= GEN_RUN;
               end
            end
            GEN_RUN: begin
               if (ready_i) begin
                  if (last_inner) begin
                     inner_q <= '0;
                     if (last_outer) begin
                        state_q <= GEN_IDLE;
                        done_o  <= 1'b1;
                     end else begin
                        outer_q <= outer_q + addr_t'(1);
                     end
                  end else begin
                     inner_q <= inner_q + period_t'(1);
                  end
               end
            end
            default: begin
               state_q <= GEN_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (run_i) begin
         per_q   <= cfg_i.per;
         duty_q  <= cfg_i.duty;
         iter_q  <= cfg_i.iter;
         incr_q  <= cfg_i.incr;
         shift_q <= cfg_i.shift;
         addr_q  <= cfg_i.start;
      end else if (step) begin
         // End of an iteration gets the shift on top of the usual incr
         if (last_inner) begin
            addr_q <= addr_q + incr_q + shift_q;
         end else begin
            addr_q <= addr_q + incr_q;
         end
      end
   end

endmodule

//--- verilog/mem_reader.sv
module mem_reader
   import vwrite_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   // Address stream from the generator
   input  logic       s_valid_i,
   input  addr_t      s_addr_i,
   output logic       s_ready_o,

   // Buffer read port
   output mem_rport_t mem_o,
   input  word_t      mem_data_i,

   // Word stream to the databus
   input  logic       m_ready_i,
   output logic       m_valid_o,
   output word_t      m_data_o
);

   logic  pending_q;
   logic  hold_valid_q;
   word_t hold_data_q;
   logic  take;
   logic  xfer;

   assign xfer = hold_valid_q && m_ready_i;

   // A new read is only issued when its word is sure to find the
   // held register free one cycle later
   assign s_ready_o = !pending_q && (!hold_valid_q || xfer);
   assign take      = s_valid_i && s_ready_o;

   assign mem_o.read = take;
   assign mem_o.addr = s_addr_i;

   assign m_valid_o = hold_valid_q;
   assign m_data_o  = hold_data_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pending_q    <= 1'b0;
         hold_valid_q <= 1'b0;
      end else begin
         pending_q <= take;
         // Held register is always empty while a read is pending
         if (pending_q) begin
            hold_valid_q <= 1'b1;
         end else if (xfer) begin
            hold_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (pending_q) begin
         hold_data_q <= mem_data_i;
      end
   end

endmodule

//--- verilog/vwrite_unit.sv
`include "vwrite_params.svh"

module vwrite_unit
   import vwrite_bus_pkg::*;
   import vwrite_cfg_pkg::*;
(
   input  logic       clk,
   input  logic       rst,

   input  logic       run_i,
   input  logic       running_i,
   output logic       done_o,

   input  logic       ping_pong_i,
   input  store_cfg_t store_cfg_i,
   input  write_cfg_t write_cfg_i,
   input  word_t      in_i,

   // Buffer ports
   output mem_wport_t mem_w_o,
   output mem_rport_t mem_r_o,
   input  word_t      mem_rdata_i,

   // Databus
   output bus_req_t   bus_o,
   input  logic       bus_ready_i,
   input  logic       bus_last_i
);

   logic      ping_state_q;
   logic      done_store_q;
   logic      done_write_q;

   gen_cfg_t  store_gen_cfg;
   gen_cfg_t  write_gen_cfg;

   logic      store_valid;
   addr_t     store_addr;
   logic      store_done;

   logic      wgen_valid;
   logic      wgen_ready;
   addr_t     wgen_addr;

   logic      rd_valid;
   word_t     rd_data;
   logic      bus_xfer;

   ext_addr_t ext_addr_q;
   len_t      len_q;

   // Store fills one half while the burst drains the other
   always_comb begin
      store_gen_cfg       = store_cfg_i.gen;
      store_gen_cfg.start = {ping_pong_i & ping_state_q,
                             store_cfg_i.gen.start[`VW_ADDR_W-2:0]};
   end

   always_comb begin
      write_gen_cfg.start = {ping_pong_i & ~ping_state_q, {(`VW_ADDR_W-1){1'b0}}};
      write_gen_cfg.per   = write_cfg_i.per;
      write_gen_cfg.duty  = write_cfg_i.duty;
      write_gen_cfg.iter  = write_cfg_i.iter;
      write_gen_cfg.incr  = write_cfg_i.incr;
      write_gen_cfg.shift = write_cfg_i.shift;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ping_state_q <= 1'b0;
      end else if (run_i) begin
         ping_state_q <= ping_pong_i ? ~ping_state_q : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_store_q <= 1'b1;
         done_write_q <= 1'b1;
      end else if (run_i) begin
         done_store_q <= 1'b0;
         if (write_cfg_i.enabled) begin
            done_write_q <= 1'b0;
         end
      end else begin
         if (running_i) begin
            done_store_q <= store_done;
         end
         if (bus_xfer && bus_last_i) begin
            done_write_q <= 1'b1;
         end
      end
   end

   // Burst address and length stay fixed for the whole run
   always_ff @(posedge clk) begin
      if (run_i && write_cfg_i.enabled) begin
         ext_addr_q <= write_cfg_i.ext_addr;
         len_q      <= write_cfg_i.len;
      end
   end

   addr_gen u_store_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .cfg_i   (store_gen_cfg),
      .delay_i (store_cfg_i.delay),
      .ready_i (1'b1),
      .valid_o (store_valid),
      .addr_o  (store_addr),
      .done_o  (store_done)
   );

   assign mem_w_o.write = store_valid;
   assign mem_w_o.addr  = store_addr;
   assign mem_w_o.data  = in_i;

   addr_gen u_write_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i && write_cfg_i.enabled),
      .cfg_i   (write_gen_cfg),
      .delay_i (delay_t'(0)),
      .ready_i (wgen_ready),
      .valid_o (wgen_valid),
      .addr_o  (wgen_addr),
      .done_o  ()
   );

   mem_reader u_reader (
      .clk        (clk),
      .rst        (rst),
      .s_valid_i  (wgen_valid),
      .s_addr_i   (wgen_addr),
      .s_ready_o  (wgen_ready),
      .mem_o      (mem_r_o),
      .mem_data_i (mem_rdata_i),
      .m_ready_i  (bus_ready_i && !done_write_q),
      .m_valid_o  (rd_valid),
      .m_data_o   (rd_data)
   );

   // No beats once the last one has gone out
   assign bus_o.valid = rd_valid && !done_write_q;
   assign bus_o.addr  = ext_addr_q;
   assign bus_o.len   = len_q;
   assign bus_o.wdata = rd_data;

   assign bus_xfer = bus_o.valid && bus_ready_i;

   assign done_o = done_store_q && done_write_q;

endmodule

//--- verif/tb_vwrite_unit.sv
`include "vwrite_params.svh"

module tb_vwrite_unit
   import vwrite_bus_pkg::*;
   import vwrite_cfg_pkg::*;
();

   logic       clk = 1'b0;
   logic       rst;
   logic       run_i;
   logic       running_i;
   logic       done_o;
   logic       ping_pong_i;
   store_cfg_t store_cfg_i;
   write_cfg_t write_cfg_i;
   word_t      in_i = '0;
   mem_wport_t mem_w_o;
   mem_rport_t mem_r_o;
   word_t      mem_rdata = '0;
   bus_req_t   bus_o;
   logic       bus_ready = 1'b0;
   logic       bus_last = 1'b0;

   word_t mem [0:(1<<`VW_ADDR_W)-1];
   word_t shadow [0:(1<<`VW_ADDR_W)-1];
   addr_t exp_store_q [$];
   word_t exp_beat_q [$];

   integer seed = 23;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;
   int     limit = 100;
   int     stores = 0;
   int     beats = 0;
   int     since_run = 0;
   logic   first_store = 1'b0;
   logic   active = 1'b0;
   logic   cur_en = 1'b0;
   int     cur_delay = 0;
   int     cur_len = 0;
   ext_addr_t cur_ext = '0;

   vwrite_unit u_vwrite_unit (
      .clk         (clk),
      .rst         (rst),
      .run_i       (run_i),
      .running_i   (running_i),
      .done_o      (done_o),
      .ping_pong_i (ping_pong_i),
      .store_cfg_i (store_cfg_i),
      .write_cfg_i (write_cfg_i),
      .in_i        (in_i),
      .mem_w_o     (mem_w_o),
      .mem_r_o     (mem_r_o),
      .mem_rdata_i (mem_rdata),
      .bus_o       (bus_o),
      .bus_ready_i (bus_ready),
      .bus_last_i  (bus_last)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("Timeout after %0d cycles, the DUT never finished", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   // Stream word and random back-pressure
   always @(posedge clk) begin
      logic [31:0] r;
      r = $random(seed);
      in_i      <= in_i + word_t'(1);
      bus_ready <= r[0];
      bus_last  <= r[0] && (beats == cur_len - 1);
   end

   // Buffer with one cycle read latency
   always @(posedge clk) begin
      if (mem_w_o.write) begin
         mem[mem_w_o.addr] <= mem_w_o.data;
      end
      if (mem_r_o.read) begin
         mem_rdata <= mem[mem_r_o.addr];
      end
   end

   task automatic check_store(input addr_t addr, input word_t data);
      addr_t exp_a;
      checks++;
      if (exp_store_q.size() == 0) begin
         $display("Unexpected buffer write to %h at time %0t", addr, $time);
         errors++;
      end else begin
         exp_a = exp_store_q.pop_front();
         if (addr !== exp_a || data !== in_i) begin
            $display("FAILED at %0t: store got %h/%h exp %h/%h",
                     $time, addr, data, exp_a, in_i);
            errors++;
         end
      end
   endtask

   task automatic check_beat(input word_t data);
      word_t exp_w;
      checks++;
      if (exp_beat_q.size() == 0) begin
         $display("Unexpected bus beat with data %h at time %0t", data, $time);
         errors++;
      end else begin
         exp_w = exp_beat_q.pop_front();
         if (data !== exp_w) begin
            $display("FAILED at %0t: beat data got %h exp %h", $time, data, exp_w);
            errors++;
         end
      end
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      checks++;
      if (got != exp) begin
         $display("FAILED at %0t: %s got %0d exp %0d", $time, what, got, exp);
         errors++;
      end
   endtask

   // Walks the generator pattern into the store queue or the beat queue
   task automatic push_pattern(input logic to_bus, input addr_t start, input int per,
                               input int duty, input int iter, input addr_t incr,
                               input addr_t shift);
      addr_t a;
      a = start;
      for (int it = 0; it < iter; it++) begin
         for (int j = 0; j < per; j++) begin
            if (j < duty) begin
               if (to_bus) begin
                  exp_beat_q.push_back(shadow[a]);
               end else begin
                  exp_store_q.push_back(a);
               end
            end
            if (j == per - 1) begin
               a = a + incr + shift;
            end else begin
               a = a + incr;
            end
         end
      end
   endtask

   // Cycle count from the run cycle, so the first cycle after run reads 1
   always @(negedge clk) begin
      if (run_i) begin
         since_run   <= 1;
         first_store <= 1'b1;
      end else begin
         since_run <= since_run + 1;
      end
      if (active && mem_w_o.write) begin
         if (first_store) begin
            check_count("first store cycle", since_run, cur_delay + 1);
            first_store <= 1'b0;
         end
         check_store(mem_w_o.addr, mem_w_o.data);
         stores <= stores + 1;
      end
      if (active && bus_o.valid && !cur_en) begin
         $display("Bus valid seen at time %0t while the write side is disabled", $time);
         errors++;
      end
      if (active && bus_o.valid && bus_ready) begin
         check_beat(bus_o.wdata);
         check_count("bus addr", int'(bus_o.addr), int'(cur_ext));
         check_count("bus len", int'(bus_o.len), cur_len);
         beats <= beats + 1;
      end
   end

   initial begin
      int    fd;
      int    n;
      int    ncase;
      string line;
      int    f [0:17];
      logic  ping_st;
      logic  st_top;
      logic  wr_top;
      int    cfg_q [$];
      store_cfg_t sc;
      write_cfg_t wc;

      rst         = 1'b1;
      run_i       = 1'b0;
      running_i   = 1'b0;
      ping_pong_i = 1'b0;
      store_cfg_i = '0;
      write_cfg_i = '0;
      ping_st     = 1'b0;
      ncase       = 0;
      for (int a = 0; a < (1 << `VW_ADDR_W); a++) begin
         mem[a] = (word_t'(a) * 32'h9E3779B1) ^ 32'h5A5A0000;
      end

      fd = $fopen("verif/vwrite_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the case file verif/vwrite_cases.txt");
         errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h %d %d",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                           f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
               if (n == 18) begin
                  for (int k = 0; k < 18; k++) begin
                     cfg_q.push_back(f[k]);
                  end
                  limit += f[8] + f[3] * f[5] + f[9] * f[11] + 4 * f[14] + 50;
               end
            end
         end
         $fclose(fd);
      end

      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_count("reset done_o", int'(done_o), 1);
      check_count("reset bus valid", int'(bus_o.valid), 0);
      check_count("reset buffer write", int'(mem_w_o.write), 0);
      check_count("reset buffer read", int'(mem_r_o.read), 0);
      @(posedge clk);

      while (cfg_q.size() >= 18) begin
         for (int k = 0; k < 18; k++) begin
            f[k] = cfg_q.pop_front();
         end
         for (int a = 0; a < (1 << `VW_ADDR_W); a++) begin
            shadow[a] = mem[a];
         end
         st_top  = f[0][0] & ping_st;
         wr_top  = f[0][0] & ~ping_st;
         ping_st = f[0][0] ? ~ping_st : 1'b0;

         sc.gen.start = addr_t'(f[2]);
         sc.gen.per   = period_t'(f[3]);
         sc.gen.duty  = period_t'(f[4]);
         sc.gen.iter  = addr_t'(f[5]);
         sc.gen.incr  = addr_t'(f[6]);
         sc.gen.shift = addr_t'(f[7]);
         sc.delay     = delay_t'(f[8]);
         wc.per       = period_t'(f[9]);
         wc.duty      = period_t'(f[10]);
         wc.iter      = addr_t'(f[11]);
         wc.incr      = addr_t'(f[12]);
         wc.shift     = addr_t'(f[13]);
         wc.len       = len_t'(f[14]);
         wc.ext_addr  = ext_addr_t'(f[15]);
         wc.enabled   = f[1][0];

         exp_store_q.delete();
         exp_beat_q.delete();
         push_pattern(1'b0, {st_top, sc.gen.start[`VW_ADDR_W-2:0]},
                      f[3], f[4], f[5], sc.gen.incr, sc.gen.shift);
         if (wc.enabled) begin
            push_pattern(1'b1, {wr_top, {(`VW_ADDR_W-1){1'b0}}},
                         f[9], f[10], f[11], wc.incr, wc.shift);
         end

         stores    = 0;
         beats     = 0;
         cur_en    = wc.enabled;
         cur_delay = f[8];
         cur_len   = wc.enabled ? f[14] : 0;
         cur_ext   = wc.ext_addr;
         active    = 1'b1;

         run_i       <= 1'b1;
         running_i   <= 1'b1;
         ping_pong_i <= f[0][0];
         store_cfg_i <= sc;
         write_cfg_i <= wc;
         @(posedge clk);
         run_i <= 1'b0;
         @(negedge clk);
         while (!done_o) begin
            @(negedge clk);
         end
         @(posedge clk);
         active = 1'b0;

         check_count("store count", stores, f[16]);
         check_count("beat count", beats, f[17]);
         check_count("stores left", exp_store_q.size(), 0);
         check_count("beats left", exp_beat_q.size(), 0);
         $display("case %0d: %0d stores, %0d beats, %0d errors so far",
                  ncase, stores, beats, errors);
         ncase++;
      end

      $display("%0d cases, %0d checks, %0d errors", ncase, checks, errors);
      if (errors == 0 && ncase > 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- verif/vwrite_cases.txt
# pp en s_start s_per s_duty s_iter s_incr s_shift s_delay
#   w_per w_duty w_iter w_incr w_shift w_len w_ext(hex) exp_stores exp_beats
# Fill the lower half, no burst
1 0 0 4 4 4 1 0 0 0 0 0 0 0 0 0 16 0
# Fill the upper half, drain the lower one
1 1 0 4 4 4 1 0 2 4 4 4 1 0 16 00001000 16 16
# Duty masking and shift on the store side
1 1 32 3 2 4 2 5 3 4 4 4 1 0 16 00002000 8 16
# Masked burst with shift
1 1 0 2 1 8 1 0 1 3 2 4 2 1 8 00003000 8 8
# No ping-pong, disjoint regions
0 1 100 2 2 5 1 0 0 2 1 6 3 0 6 00004000 10 6
# Store only with long delay
1 0 5 5 3 3 1 2 4 0 0 0 0 0 0 0 9 0
# Single step periods
1 1 0 1 1 10 1 0 0 1 1 10 4 0 10 00005000 10 10
# Back to the lower half
1 1 64 2 2 3 1 4 15 1 1 10 1 0 10 00006000 6 10

//--- list.f
+incdir+verilog
verilog/vwrite_bus_pkg.sv
verilog/vwrite_cfg_pkg.sv
verilog/addr_gen.sv
verilog/mem_reader.sv
verilog/vwrite_unit.sv
verif/tb_vwrite_unit.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vwrite_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
